// ==== hw/rv32i_isa_pkg.sv ====
package rv32i_isa_pkg;

	// data and instruction words
	typedef logic [31:0] word_t;
	typedef logic [31:0] instr_t;

	// architectural register number
	typedef logic [4:0] reg_idx_t;

	localparam int NUM_REGS = 32;

	// major opcodes the core understands
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111
	} opcode_t;

	// funct3 values shared by OP and OP_IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// operations of the single alu
	// PASS_B forwards operand b, used by LUI
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_t;

endpackage

// ==== hw/ooo_ctrl_pkg.sv ====
package ooo_ctrl_pkg;

	// reorder buffer depth, must be a power of two so pointers wrap freely
	localparam int ROB_SIZE = 8;

	// tag names one rob entry
	typedef logic [$clog2(ROB_SIZE)-1:0] rob_tag_t;

	// occupancy needs one extra bit to tell full from empty
	typedef logic [$clog2(ROB_SIZE):0] rob_cnt_t;

	// reservation station slots in front of the alu
	localparam int RS_SIZE = 4;

	// slot life cycle
	// FREE     nothing held
	// WAITING  at least one operand still tagged
	// READY    both operands present, can issue
	typedef enum logic [1:0] {
		RS_FREE,
		RS_WAITING,
		RS_READY
	} rs_state_t;

endpackage

// ==== hw/instr_decode.sv ====
`timescale 1ns/1ns

module instr_decode import rv32i_isa_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     instr_valid,
	input  instr_t   instr,
	input  logic     rob_full,
	input  logic     rs_full,
	output logic     instr_ready,
	output logic     disp_valid,
	output reg_idx_t rs1,
	output reg_idx_t rs2,
	output reg_idx_t rd,
	output alu_op_t  alu_op,
	output word_t    imm,
	output logic     use_imm,
	output logic     writes_rd
);

	opcode_t    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	// raw field slices
	assign opcode = opcode_t'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25]; 
	assign rd     = instr[11:7];
	assign rs2    = instr[24:20];

	// one instruction per cycle, stall on either structure full
	assign instr_ready = !rob_full && !rs_full;
	assign disp_valid  = instr_valid && instr_ready;

	always_comb begin
		// defaults describe a register-register op
		rs1       = instr[19:15];
		imm       = {{20{instr[31]}}, instr[31:20]};
		use_imm   = 1'b0;
		writes_rd = (rd != 5'd0);
		alu_op    = ALU_ADD;
		case (opcode)
			OPC_OP, OPC_OP_IMM: begin
				use_imm = (opcode == OPC_OP_IMM);
				case (funct3)
					// SUB only exists in the register form
					F3_ADD_SUB: alu_op = (funct7[5] && !use_imm) ? ALU_SUB : ALU_ADD;
					F3_SLL:     alu_op = ALU_SLL;
					F3_SLT:     alu_op = ALU_SLT;
					F3_SLTU:    alu_op = ALU_SLTU;
					F3_XOR:     alu_op = ALU_XOR;
					// bit 30 picks arithmetic shift in both forms
					F3_SRL_SRA: alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
					F3_OR:      alu_op = ALU_OR;
					default:    alu_op = ALU_AND;
				endcase
			end
			OPC_LUI: begin
				// u-type immediate, rs1 forced to x0 so no dependency appears
				rs1     = 5'd0;
				imm     = {instr[31:12], 12'd0};
				use_imm = 1'b1;
				alu_op  = ALU_PASS_B;
			end
			default: begin
				writes_rd = 1'b0;
			end
		endcase
	end

	// a stalled word stays on the bus unchanged until decode takes it
	a_instr_held: assert property (@(posedge clk) disable iff (rst)
		instr_valid && !instr_ready |=> instr_valid && $stable(instr));

endmodule

// ==== hw/regfile.sv ====
`timescale 1ns/1ns

module regfile import rv32i_isa_pkg::*, ooo_ctrl_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  reg_idx_t            rs1,
	input  reg_idx_t            rs2,
	input  reg_idx_t            rd,
	input  logic                disp_valid,
	input  logic                writes_rd,
	input  rob_tag_t            rd_tag,
	input  logic [ROB_SIZE-1:0] rob_rdy,
	input  word_t               rob_data [ROB_SIZE],
	input  logic                commit_valid,
	input  logic                commit_ready,
	input  reg_idx_t            commit_rd,
	input  rob_tag_t            commit_tag,
	input  word_t               commit_data,
	output logic                op1_busy,
	output word_t               op1,
	output logic                op2_busy,
	output word_t               op2
);

	// per register state
	word_t    regs [NUM_REGS];
	logic     busy [NUM_REGS];
	rob_tag_t tags [NUM_REGS];

	logic commit_fire;

	assign commit_fire = commit_valid && commit_ready;

	// still waiting only when the producer has not written the rob yet
	function automatic logic src_busy(reg_idx_t r);
		return busy[r] && !rob_rdy[tags[r]];
	endfunction

	// value from the rob when the producer is done but not retired,
	// the producer tag when it is still running, else the register
	function automatic word_t src_val(reg_idx_t r);
		word_t v;
		if (busy[r] && rob_rdy[tags[r]]) begin
			v = rob_data[tags[r]];
		end else if (busy[r]) begin
			v = word_t'(tags[r]);
		end else begin
			v = regs[r];
		end
		return v;
	endfunction

	always_comb begin
		op1_busy = src_busy(rs1);
		op1      = src_val(rs1);
		op2_busy = src_busy(rs2);
		op2      = src_val(rs2);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
				busy[i] <= 1'b0;
				tags[i] <= '0;
			end
		end else begin
			// retire in program order, x0 stays zero
			if (commit_fire && commit_rd != 5'd0) begin
				regs[commit_rd] <= commit_data;
				// a younger writer keeps the register if it renamed it meanwhile
				if (tags[commit_rd] == commit_tag) begin
					busy[commit_rd] <= 1'b0;
				end
			end
			// rename comes after commit so a same-edge dispatch wins ownership
			if (disp_valid && writes_rd) begin
				busy[rd] <= 1'b1;
				tags[rd] <= rd_tag;
			end
		end
	end

	// x0 must never be renamed, decode and rob both map non-writers to it
	a_x0_never_busy: assert property (@(posedge clk) disable iff (rst)
		!busy[0]);

endmodule

// ==== hw/alu_execute.sv ====
`timescale 1ns/1ns

module alu_execute import rv32i_isa_pkg::*, ooo_ctrl_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     disp_valid,
	input  alu_op_t  alu_op,
	input  word_t    imm,
	input  logic     use_imm,
	input  logic     op1_busy,
	input  word_t    op1,
	input  logic     op2_busy,
	input  word_t    op2,
	input  rob_tag_t disp_tag,
	output logic     rs_full,
	output logic     res_valid,
	output rob_tag_t res_tag,
	output word_t    res_data
);

	// slot contents
	rs_state_t                  slot_state [RS_SIZE];
	alu_op_t                    slot_op    [RS_SIZE];
	rob_tag_t                   slot_tag   [RS_SIZE];
	// age counts how many occupied slots are younger, largest is oldest
	logic [$clog2(RS_SIZE)-1:0] slot_age   [RS_SIZE];
	word_t                      val1       [RS_SIZE];
	word_t                      val2       [RS_SIZE];
	logic                       rdy1       [RS_SIZE];
	logic                       rdy2       [RS_SIZE];
	rob_tag_t                   src1       [RS_SIZE];
	rob_tag_t                   src2       [RS_SIZE];

	logic                       hit1 [RS_SIZE];
	logic                       hit2 [RS_SIZE];
	logic                       alloc_hit;
	logic [$clog2(RS_SIZE)-1:0] alloc_idx;
	logic                       iss_hit;
	logic [$clog2(RS_SIZE)-1:0] iss_idx;
	logic                       cap1;
	logic                       cap2;

	function automatic word_t alu_calc(alu_op_t op, word_t a, word_t b);
		word_t r;
		case (op)
			ALU_ADD:  r = a + b;
			ALU_SUB:  r = a - b;
			ALU_SLL:  r = a << b[4:0];
			ALU_SLT:  r = {31'd0, $signed(a) < $signed(b)};
			ALU_SLTU: r = {31'd0, a < b};
			ALU_XOR:  r = a ^ b;
			ALU_SRL:  r = a >> b[4:0];
			ALU_SRA:  r = word_t'($signed(a) >>> b[4:0]);
			ALU_OR:   r = a | b;
			ALU_AND:  r = a & b;
			default:  r = b;
		endcase
		return r;
	endfunction

	always_comb begin
		alloc_hit = 1'b0;
		alloc_idx = '0;
		iss_hit   = 1'b0;
		iss_idx   = '0;
		for (int i = 0; i < RS_SIZE; i++) begin
			// snoop own result bus for tagged operands
			hit1[i] = res_valid && !rdy1[i] && res_tag == src1[i];
			hit2[i] = res_valid && !rdy2[i] && res_tag == src2[i];
			// first free slot takes the next dispatch
			if (slot_state[i] == RS_FREE && !alloc_hit) begin
				alloc_hit = 1'b1;
				alloc_idx = i[$clog2(RS_SIZE)-1:0];
			end
			// oldest ready slot goes to the alu
			if (slot_state[i] == RS_READY && (!iss_hit || slot_age[i] > slot_age[iss_idx])) begin
				iss_hit = 1'b1;
				iss_idx = i[$clog2(RS_SIZE)-1:0];
			end
		end
		rs_full = !alloc_hit;
		// operand arriving on the result bus in the dispatch cycle counts as present
		cap1 = !op1_busy || (res_valid && res_tag == rob_tag_t'(op1));
		cap2 = use_imm || !op2_busy || (res_valid && res_tag == rob_tag_t'(op2));
	end

	// control state
	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
			for (int i = 0; i < RS_SIZE; i++) begin
				slot_state[i] <= RS_FREE;
				slot_age[i]   <= '0;
				rdy1[i]       <= 1'b0;
				rdy2[i]       <= 1'b0;
			end
		end else begin
			res_valid <= iss_hit;
			for (int i = 0; i < RS_SIZE; i++) begin
				if (disp_valid && alloc_idx == i) begin
					slot_state[i] <= (cap1 && cap2) ? RS_READY : RS_WAITING;
					slot_age[i]   <= '0;
					rdy1[i]       <= cap1;
					rdy2[i]       <= cap2;
				end else if (slot_state[i] != RS_FREE) begin
					// one younger on dispatch, one older gone on issue
					slot_age[i] <= slot_age[i] + (disp_valid ? 1'b1 : 1'b0)
						- ((iss_hit && slot_age[i] > slot_age[iss_idx]) ? 1'b1 : 1'b0);
					if (hit1[i]) rdy1[i] <= 1'b1;
					if (hit2[i]) rdy2[i] <= 1'b1;
					if (iss_hit && iss_idx == i) begin
						slot_state[i] <= RS_FREE;
					end else if (slot_state[i] == RS_WAITING &&
						(rdy1[i] || hit1[i]) && (rdy2[i] || hit2[i])) begin
						slot_state[i] <= RS_READY;
					end
				end
			end
		end
	end

	// payload, no reset needed
	always_ff @(posedge clk) begin
		res_tag  <= slot_tag[iss_idx];
		res_data <= alu_calc(slot_op[iss_idx], val1[iss_idx], val2[iss_idx]);
		for (int i = 0; i < RS_SIZE; i++) begin
			if (disp_valid && alloc_idx == i) begin
				slot_op[i]  <= alu_op;
				slot_tag[i] <= disp_tag;
				val1[i]     <= op1_busy ? res_data : op1;
				src1[i]     <= rob_tag_t'(op1);
				val2[i]     <= use_imm ? imm : (op2_busy ? res_data : op2);
				src2[i]     <= rob_tag_t'(op2);
			end else begin
				if (hit1[i]) val1[i] <= res_data;
				if (hit2[i]) val2[i] <= res_data;
			end
		end
	end

	// decode gates dispatch, this side must never see a capture with no room
	a_no_capture_when_full: assert property (@(posedge clk) disable iff (rst)
		disp_valid |-> !rs_full);

endmodule

// ==== hw/reorder_buffer.sv ====
`timescale 1ns/1ns

module reorder_buffer import rv32i_isa_pkg::*, ooo_ctrl_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                disp_valid,
	input  reg_idx_t            disp_rd,
	input  logic                disp_writes_rd,
	input  logic                res_valid,
	input  rob_tag_t            res_tag,
	input  word_t               res_data,
	input  logic                commit_ready,
	output rob_tag_t            rob_alloc_tag,
	output logic                rob_full,
	output logic [ROB_SIZE-1:0] rob_rdy,
	output word_t               rob_data [ROB_SIZE],
	output logic                commit_valid,
	output reg_idx_t            commit_rd,
	output rob_tag_t            commit_tag,
	output word_t               commit_data
);

	rob_tag_t            head;
	rob_tag_t            tail;
	rob_cnt_t            count;
	// entry holds an instruction between dispatch and commit
	logic [ROB_SIZE-1:0] used;
	// result written
	logic [ROB_SIZE-1:0] done;
	word_t               data_q [ROB_SIZE];
	reg_idx_t            rd_q   [ROB_SIZE];

	logic commit_fire;

	// new entries go at the tail, tag is the slot index
	assign rob_alloc_tag = tail;
	assign rob_full      = (count == rob_cnt_t'(ROB_SIZE));

	// state seen by the register file for forwarding
	assign rob_rdy  = done;
	assign rob_data = data_q;

	// head retires once its result is in
	assign commit_valid = (count != '0) && done[head];
	assign commit_rd    = rd_q[head];
	assign commit_tag   = head;
	assign commit_data  = data_q[head];
	assign commit_fire  = commit_valid && commit_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			used  <= '0;
			done  <= '0;
		end else begin
			if (disp_valid) begin
				used[tail] <= 1'b1;
				done[tail] <= 1'b0;
				tail       <= tail + 1'b1;
			end
			if (res_valid) begin
				done[res_tag] <= 1'b1;
			end
			if (commit_fire) begin
				used[head] <= 1'b0;
				done[head] <= 1'b0;
				head       <= head + 1'b1;
			end
			// net occupancy change
			count <= count + (disp_valid ? 1'b1 : 1'b0) - (commit_fire ? 1'b1 : 1'b0);
		end
	end

	// entry payload
	always_ff @(posedge clk) begin
		if (disp_valid) begin
			// non-writers retire against x0 so nothing is updated
			rd_q[tail] <= disp_writes_rd ? disp_rd : 5'd0;
		end
		if (res_valid) begin
			data_q[res_tag] <= res_data;
		end
	end

	// a result must belong to an instruction still in flight
	a_res_to_live_entry: assert property (@(posedge clk) disable iff (rst)
		res_valid |-> used[res_tag] && !done[res_tag]);

	// held commit keeps its payload
	a_commit_stable: assert property (@(posedge clk) disable iff (rst)
		commit_valid && !commit_ready |=> commit_valid && $stable(commit_rd)
			&& $stable(commit_data));

endmodule

// ==== hw/ooo_core_top.sv ====
`timescale 1ns/1ns

module ooo_core_top import rv32i_isa_pkg::*, ooo_ctrl_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     instr_valid,
	input  instr_t   instr,
	input  logic     commit_ready,
	output logic     instr_ready,
	output logic     commit_valid,
	output reg_idx_t commit_rd,
	output word_t    commit_data
);

	// dispatch
	logic     disp_valid;
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	alu_op_t  alu_op;
	word_t    imm;
	logic     use_imm;
	logic     writes_rd;
	logic     rob_full;
	logic     rs_full;
	rob_tag_t rob_alloc_tag;

	// operands
	logic  op1_busy;
	word_t op1;
	logic  op2_busy;
	word_t op2;

	// result bus and rob state
	logic                res_valid;
	rob_tag_t            res_tag;
	word_t               res_data;
	logic [ROB_SIZE-1:0] rob_rdy;
	word_t               rob_data [ROB_SIZE];
	rob_tag_t            commit_tag;

	instr_decode i_instr_decode (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.rob_full    (rob_full),
		.rs_full     (rs_full),
		.instr_ready (instr_ready),
		.disp_valid  (disp_valid),
		.rs1         (rs1),
		.rs2         (rs2),
		.rd          (rd),
		.alu_op      (alu_op),
		.imm         (imm),
		.use_imm     (use_imm),
		.writes_rd   (writes_rd)
	);

	regfile i_regfile (
		.clk          (clk),
		.rst          (rst),
		.rs1          (rs1),
		.rs2          (rs2),
		.rd           (rd),
		.disp_valid   (disp_valid),
		.writes_rd    (writes_rd),
		.rd_tag       (rob_alloc_tag),
		.rob_rdy      (rob_rdy),
		.rob_data     (rob_data),
		.commit_valid (commit_valid),
		.commit_ready (commit_ready),
		.commit_rd    (commit_rd),
		.commit_tag   (commit_tag),
		.commit_data  (commit_data),
		.op1_busy     (op1_busy),
		.op1          (op1),
		.op2_busy     (op2_busy),
		.op2          (op2)
	);

	alu_execute i_alu_execute (
		.clk        (clk),
		.rst        (rst),
		.disp_valid (disp_valid),
		.alu_op     (alu_op),
		.imm        (imm),
		.use_imm    (use_imm),
		.op1_busy   (op1_busy),
		.op1        (op1),
		.op2_busy   (op2_busy),
		.op2        (op2),
		.disp_tag   (rob_alloc_tag),
		.rs_full    (rs_full),
		.res_valid  (res_valid),
		.res_tag    (res_tag),
		.res_data   (res_data)
	);

	reorder_buffer i_reorder_buffer (
		.clk            (clk),
		.rst            (rst),
		.disp_valid     (disp_valid),
		.disp_rd        (rd),
		.disp_writes_rd (writes_rd),
		.res_valid      (res_valid),
		.res_tag        (res_tag),
		.res_data       (res_data),
		.commit_ready   (commit_ready),
		.rob_alloc_tag  (rob_alloc_tag),
		.rob_full       (rob_full),
		.rob_rdy        (rob_rdy),
		.rob_data       (rob_data),
		.commit_valid   (commit_valid),
		.commit_rd      (commit_rd),
		.commit_tag     (commit_tag),
		.commit_data    (commit_data)
	);

endmodule

// ==== bench/ooo_core_tb.sv ====
`timescale 1ns/1ns

module ooo_core_tb import rv32i_isa_pkg::*, ooo_ctrl_pkg::*; ();

	localparam int NUM_INSTR      = 300;
	localparam int TIMEOUT_CYCLES = 40 * NUM_INSTR + 100;
	// commit_ready is held low for the last STALL_LEN cycles of every PERIOD
	localparam int PERIOD         = 160;
	localparam int STALL_LEN      = 6 * ROB_SIZE;

	logic     clk;
	logic     rst;
	logic     instr_valid;
	instr_t   instr;
	logic     commit_ready;
	logic     instr_ready;
	logic     commit_valid;
	reg_idx_t commit_rd;
	word_t    commit_data;

	// stimulus state
	logic [31:0] lfsr_state;
	reg_idx_t    last_rd;
	int          sent;
	int          cyc;
	int          cycles;

	// golden model and expected commit stream
	word_t       gold_regs [NUM_REGS];
	reg_idx_t    exp_rd_q [$];
	word_t       exp_data_q [$];
	logic        head_present;
	reg_idx_t    head_rd;
	word_t       head_data;
	// commit payload seen at the previous edge
	reg_idx_t    held_rd;
	word_t       held_data;
	logic        accepted_any;
	logic        saw_ready_low;
	int          acc_count;
	int          commit_count;
	int          value_errs;
	int          proto_errs;

	ooo_core_top i_ooo_core_top (
		.clk          (clk),
		.rst          (rst),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.commit_ready (commit_ready),
		.instr_ready  (instr_ready),
		.commit_valid (commit_valid),
		.commit_rd    (commit_rd),
		.commit_data  (commit_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			v          = {v[30:0], lfsr_state[31]};
			lfsr_state = {lfsr_state[30:0], fb};
		end
		return v;
	endfunction

	// mostly x0..x7 so producers and consumers collide often
	function automatic reg_idx_t pick_reg();
		if (rand_bits(3) == 0) begin
			return reg_idx_t'(rand_bits(5));
		end
		return reg_idx_t'(rand_bits(3));
	endfunction

	function automatic instr_t gen_instr();
		logic [1:0]  kind;
		logic [2:0]  f3;
		logic        alt;
		logic [11:0] imm12;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		instr_t      w;
		kind  = 2'(rand_bits(2));
		f3    = 3'(rand_bits(3));
		alt   = (rand_bits(1) != 0);
		imm12 = 12'(rand_bits(12));
		rd    = pick_reg();
		rs1   = pick_reg();
		rs2   = pick_reg();
		// back-to-back chains through the last destination
		if (rand_bits(2) == 0) begin
			rs1 = last_rd;
		end
		if (rand_bits(2) == 0) begin
			rs2 = last_rd;
		end
		case (kind)
			2'd2: begin
				// shift amount only in imm[4:0], bit 30 selects sra
				if (f3 == 3'd1) begin
					imm12 = {7'd0, imm12[4:0]};
				end
				if (f3 == 3'd5) begin
					imm12 = {1'b0, alt, 5'd0, imm12[4:0]};
				end
				w = {imm12, rs1, f3, rd, OPC_OP_IMM};
			end
			2'd3: w = {imm12, 8'(rand_bits(8)), rd, OPC_LUI};
			// funct7 bit 30 only meaningful for sub and sra
			default: w = {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'd0, rs2, rs1, f3, rd, OPC_OP};
		endcase
		last_rd = rd;
		return w;
	endfunction

	// sequential rv32i semantics on the golden register file
	function automatic word_t golden_result(instr_t w);
		word_t a;
		word_t b;
		word_t r;
		a = gold_regs[w[19:15]];
		b = (w[6:0] == OPC_OP) ? gold_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
		if (w[6:0] == OPC_LUI) begin
			return {w[31:12], 12'd0};
		end
		case (w[14:12])
			3'd0: r = (w[6:0] == OPC_OP && w[30]) ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: r = (a < b) ? 32'd1 : 32'd0;
			3'd4: r = a ^ b;
			3'd5: begin
				if (w[30]) begin
					r = $signed(a) >>> b[4:0];
				end else begin
					r = a >> b[4:0];
				end
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	task automatic print_summary();
		$display("errors: value %0d, protocol %0d; accepted %0d, committed %0d",
			value_errs, proto_errs, acc_count, commit_count);
	endtask

	// monitor, golden execution on accept and pop on commit
	always @(posedge clk) begin
		word_t res;
		held_rd   <= commit_rd;
		held_data <= commit_data;
		if (!rst) begin
			if (!instr_ready) begin
				saw_ready_low <= 1'b1;
			end
			if (instr_valid && instr_ready) begin
				res = golden_result(instr);
				exp_rd_q.push_back(instr[11:7]);
				exp_data_q.push_back(res);
				// x0 keeps reading zero
				if (instr[11:7] != 5'd0) begin
					gold_regs[instr[11:7]] = res;
				end
				acc_count    <= acc_count + 1;
				accepted_any <= 1'b1;
			end
			if (commit_valid && commit_ready) begin
				if (exp_rd_q.size() > 0) begin
					void'(exp_rd_q.pop_front());
					void'(exp_data_q.pop_front());
				end
				commit_count <= commit_count + 1;
			end
			head_present <= (exp_rd_q.size() > 0);
			if (exp_rd_q.size() > 0) begin
				head_rd   <= exp_rd_q[0];
				head_data <= exp_data_q[0];
			end
		end
	end

	a_commit_expected: assert property (@(posedge clk) disable iff (rst)
		commit_valid && commit_ready |-> head_present)
		else begin
			proto_errs++;
			$display("ERROR: commit arrived with no accepted instruction outstanding");
		end

	a_commit_rd: assert property (@(posedge clk) disable iff (rst)
		commit_valid && commit_ready && head_present |-> commit_rd == head_rd)
		else begin
			value_errs++;
			$display("FAILED commit_rd expected %h got %h", $sampled(head_rd), $sampled(commit_rd));
		end

	// data of an x0 writer goes nowhere
	a_commit_data: assert property (@(posedge clk) disable iff (rst)
		commit_valid && commit_ready && head_present && head_rd != 5'd0
		|-> commit_data == head_data)
		else begin
			value_errs++;
			$display("FAILED commit_data expected %h got %h",
				$sampled(head_data), $sampled(commit_data));
		end

	a_hold_valid: assert property (@(posedge clk) disable iff (rst)
		commit_valid && !commit_ready |=> commit_valid)
		else begin
			proto_errs++;
			$display("ERROR: commit_valid dropped before its transfer");
		end

	a_hold_rd: assert property (@(posedge clk) disable iff (rst)
		commit_valid && !commit_ready |=> commit_rd == held_rd)
		else begin
			value_errs++;
			$display("FAILED commit_rd expected %h got %h", $sampled(held_rd), $sampled(commit_rd));
		end

	a_hold_data: assert property (@(posedge clk) disable iff (rst)
		commit_valid && !commit_ready |=> commit_data == held_data)
		else begin
			value_errs++;
			$display("FAILED commit_data expected %h got %h",
				$sampled(held_data), $sampled(commit_data));
		end

	a_idle_after_reset: assert property (@(posedge clk) disable iff (rst)
		!accepted_any |-> !commit_valid)
		else begin
			proto_errs++;
			$display("ERROR: commit_valid rose before any instruction was accepted");
		end

	// stimulus must stay inside the supported subset
	a_opcode_legal: assert property (@(posedge clk) disable iff (rst)
		instr_valid |-> instr[6:0] inside {OPC_OP, OPC_OP_IMM, OPC_LUI})
		else begin
			proto_errs++;
			$display("ERROR: stimulus sent an unsupported opcode");
		end

	initial begin
		rst           = 1'b1;
		instr_valid   = 1'b0;
		instr         = '0;
		commit_ready  = 1'b0;
		lfsr_state    = 32'h422;
		last_rd       = '0;
		sent          = 0;
		cyc           = 0;
		acc_count     = 0;
		commit_count  = 0;
		value_errs    = 0;
		proto_errs    = 0;
		head_present  = 1'b0;
		accepted_any  = 1'b0;
		saw_ready_low = 1'b0;
		for (int i = 0; i < NUM_REGS; i++) begin
			gold_regs[i] = '0;
		end
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		while (sent < NUM_INSTR || commit_count < NUM_INSTR) begin
			@(posedge clk);
			cyc++;
			if (instr_valid && instr_ready) begin
				sent++;
			end
			// new word only once the current one is gone
			if (!instr_valid || instr_ready) begin
				if (cyc > 6 && sent < NUM_INSTR && rand_bits(2) != 0) begin
					instr       <= gen_instr();
					instr_valid <= 1'b1;
				end else begin
					instr_valid <= 1'b0;
				end
			end
			// long stall fills the rob, otherwise random back-pressure
			if (cyc % PERIOD >= PERIOD - STALL_LEN) begin
				commit_ready <= 1'b0;
			end else begin
				commit_ready <= (rand_bits(2) != 0);
			end
		end
		repeat (4) @(posedge clk);
		a_all_retired: assert (commit_count == acc_count && exp_rd_q.size() == 0)
			else begin
				proto_errs++;
				$display("ERROR: %0d instructions accepted but %0d committed",
					acc_count, commit_count);
			end
		a_saw_backpressure: assert (saw_ready_low)
			else begin
				proto_errs++;
				$display("ERROR: instr_ready never fell while commits were held");
			end
		print_summary();
		if (value_errs == 0 && proto_errs == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("ERROR: timeout after %0d cycles, commits stalled", cycles);
		print_summary();
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
hw/rv32i_isa_pkg.sv
hw/ooo_ctrl_pkg.sv
hw/instr_decode.sv
hw/regfile.sv
hw/alu_execute.sv
hw/reorder_buffer.sv
hw/ooo_core_top.sv
bench/ooo_core_tb.sv

// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - hw/rv32i_isa_pkg.sv
  - hw/ooo_ctrl_pkg.sv
  - hw/instr_decode.sv
  - hw/regfile.sv
  - hw/alu_execute.sv
  - hw/reorder_buffer.sv
  - hw/ooo_core_top.sv
  - target: test
    files:
      - bench/ooo_core_tb.sv
